// File: design/periph_pkg.sv
// Shared constants and types; register selects 8 to 15 decode to nothing and read as zero
package periph_pkg;

  ////////////////////
  // Widths

  localparam int data_w  = 8;
  localparam int tm_w    = 12;
  localparam int psc_w   = 3;
  localparam int num_int = 4;

  ////////////////////
  // Special register select

  typedef enum logic [3:0] {
    spr_pa  = 4'd0,
    spr_pb  = 4'd1,
    spr_pc  = 4'd2,
    spr_mk  = 4'd3,
    spr_mb  = 4'd4,
    spr_mc  = 4'd5,
    spr_tm0 = 4'd6,
    spr_tm1 = 4'd7
  } spr_sel_t;

  ////////////////////
  // Interrupts

  // Lowest index wins
  typedef enum logic [1:0] {
    ii_int0 = 2'd0,
    ii_intt = 2'd1,
    ii_int1 = 2'd2,
    ii_int2 = 2'd3
  } int_idx_t;

  typedef logic [7:0] int_vec_t;

  localparam int_vec_t vec_int0 = 8'h04;
  localparam int_vec_t vec_intt = 8'h08;
  localparam int_vec_t vec_int1 = 8'h10;
  localparam int_vec_t vec_int2 = 8'h20;

  // Reset values
  localparam logic [data_w-1:0] mk_reset   = 8'hff;
  localparam logic [data_w-1:0] mode_reset = 8'hff;
  localparam logic [tm_w-1:0]   tm_reset   = 12'hfff;

  // Oldest sample in the MSB: one low then three highs
  localparam logic [3:0] int_filter_pattern = 4'b0111;

endpackage

// File: design/spr_file.sv
// Special registers; writes land at the next CLK edge, read-back is combinational, TM1 holds 4 bits
`timescale 1ns/1ns

module spr_file (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          spr_wr,
  input  periph_pkg::spr_sel_t          spr_sel,
  input  logic [periph_pkg::data_w-1:0] spr_wdata,
  input  logic [periph_pkg::data_w-1:0] pb_in,
  input  logic [periph_pkg::data_w-1:0] pc_in,
  output logic [periph_pkg::data_w-1:0] spr_rdata,
  output logic [periph_pkg::data_w-1:0] pa_out,
  output logic [periph_pkg::data_w-1:0] pb_out,
  output logic [periph_pkg::data_w-1:0] pb_oe,
  output logic [periph_pkg::data_w-1:0] pc_out,
  output logic [periph_pkg::data_w-1:0] pc_oe,
  output logic [periph_pkg::data_w-1:0] mk,
  output logic [periph_pkg::tm_w-1:0]   tm_reload
);

  logic [periph_pkg::data_w-1:0] pa_r;
  logic [periph_pkg::data_w-1:0] pb_r;
  logic [periph_pkg::data_w-1:0] pc_r;
  logic [periph_pkg::data_w-1:0] mb_r;
  logic [periph_pkg::data_w-1:0] mc_r;
  logic [periph_pkg::data_w-1:0] mk_r;
  logic [periph_pkg::tm_w-1:0]   tm_r;

  ////////////////////
  // Register writes

  always_ff @(posedge CLK) begin
    if (rst) begin
      pa_r <= '0;
      pb_r <= '0;
      pc_r <= '0;
      mb_r <= periph_pkg::mode_reset;
      mc_r <= periph_pkg::mode_reset;
      mk_r <= periph_pkg::mk_reset;
      tm_r <= periph_pkg::tm_reset;
    end else if (spr_wr) begin
      case (spr_sel)
        periph_pkg::spr_pa:  pa_r <= spr_wdata;
        periph_pkg::spr_pb:  pb_r <= spr_wdata;
        periph_pkg::spr_pc:  pc_r <= spr_wdata;
        periph_pkg::spr_mk:  mk_r <= spr_wdata;
        periph_pkg::spr_mb:  mb_r <= spr_wdata;
        periph_pkg::spr_mc:  mc_r <= spr_wdata;
        periph_pkg::spr_tm0: tm_r[7:0] <= spr_wdata;
        periph_pkg::spr_tm1: tm_r[11:8] <= spr_wdata[3:0];
        default: ;
      endcase
    end
  end

  ////////////////////
  // Port pin control

  // Mode bit set means input
  assign pb_oe = ~mb_r;

  // PC6..PC2 are fixed, PC7 and PC1..PC0 follow MC
  assign pc_oe = {~mc_r[7], 5'b11110, ~mc_r[1:0]};

  assign pa_out = pa_r;
  assign pb_out = pb_r;
  // Control-function pins keep their port data off the pin
  assign pc_out = pc_r & {mc_r[7:2], ~mc_r[1:0]};

  assign mk        = mk_r;
  assign tm_reload = tm_r;

  ////////////////////
  // Read-back

  always_comb begin
    case (spr_sel)
      periph_pkg::spr_pa:  spr_rdata = pa_r;
      periph_pkg::spr_pb:  spr_rdata = (pb_in & ~pb_oe) | (pb_r & pb_oe);
      periph_pkg::spr_pc:  spr_rdata = (pc_in & ~pc_oe) | (pc_r & pc_oe);
      periph_pkg::spr_mk:  spr_rdata = mk_r;
      periph_pkg::spr_mb:  spr_rdata = mb_r;
      periph_pkg::spr_mc:  spr_rdata = mc_r;
      periph_pkg::spr_tm0: spr_rdata = tm_r[7:0];
      periph_pkg::spr_tm1: spr_rdata = {4'b0000, tm_r[11:8]};
      default:             spr_rdata = '0;
    endcase
  end

endmodule

// File: design/timer.sv
// Timer counts every CLK; underflow comes (TM+1)*8 cycles after a reload, no timer output pin
`timescale 1ns/1ns

module timer (
  input  logic                        CLK,
  input  logic                        rst,
  input  logic                        stm,
  input  logic [periph_pkg::tm_w-1:0] tm_reload,
  output logic                        timer_uf
);

  localparam int cnt_w = periph_pkg::tm_w + periph_pkg::psc_w;

  // Upper bits are the 12-bit count, lower bits the /8 prescaler
  logic [cnt_w-1:0] cnt;
  logic             reload;

  ////////////////////
  // Underflow

  assign timer_uf = (cnt == '0);

  // Either source restarts the prescaler as well
  assign reload = timer_uf | stm;

  ////////////////////
  // Down counter

  always_ff @(posedge CLK) begin
    if (rst) begin
      cnt <= '1;
    end else if (reload) begin
      cnt <= {tm_reload, {periph_pkg::psc_w{1'b1}}};
    end else begin
      cnt <= cnt - cnt_w'(1);
    end
  end

endmodule

// File: design/int_ctrl.sv
// Interrupt controller; INT1/INT2 need 3 high samples after a low, INT0 is level, no INTS source
`timescale 1ns/1ns

module int_ctrl (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          int0,
  input  logic                          int1,
  input  logic                          int2,
  input  logic                          timer_uf,
  input  logic [periph_pkg::data_w-1:0] mk,
  input  logic                          fetch,
  input  logic                          ie_wr,
  input  logic                          ie_val,
  input  logic                          irf_clr,
  input  periph_pkg::int_idx_t          irf_idx,
  output logic                          int_req,
  output periph_pkg::int_vec_t          int_vector,
  output logic                          ie,
  output logic                          irf_hit
);

  logic [3:0]                     int1_hist;
  logic [3:0]                     int2_hist;
  logic [periph_pkg::num_int-1:0] pend;
  logic [periph_pkg::num_int-1:0] pend_set;
  logic [periph_pkg::num_int-1:0] pend_clr;
  logic [periph_pkg::num_int-1:0] ack_clr;
  logic [periph_pkg::num_int-1:0] enabled;
  logic [periph_pkg::num_int-1:0] taken;
  logic [periph_pkg::num_int-1:0] ack;

  ////////////////////
  // Edge filters

  always_ff @(posedge CLK) begin
    if (rst) begin
      int1_hist <= '0;
      int2_hist <= '0;
    end else begin
      int1_hist <= {int1_hist[2:0], int1};
      // MK5 low selects falling-edge INT2
      int2_hist <= {int2_hist[2:0], int2 ^ ~mk[5]};
    end
  end

  ////////////////////
  // Pending flags

  always_comb begin
    pend_set = '0;
    pend_set[periph_pkg::ii_int0] = int0 & ~pend[periph_pkg::ii_int0];
    pend_set[periph_pkg::ii_intt] = timer_uf;
    pend_set[periph_pkg::ii_int1] = (int1_hist == periph_pkg::int_filter_pattern);
    pend_set[periph_pkg::ii_int2] = (int2_hist == periph_pkg::int_filter_pattern);
  end

  // Taken source is retired at the next fetch
  assign ack_clr = fetch ? ack : '0;

  always_comb begin
    pend_clr = ack_clr;
    pend_clr[periph_pkg::ii_int0] = ack_clr[periph_pkg::ii_int0] | ~int0;
    if (irf_clr) begin
      pend_clr[irf_idx] = 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (rst) begin
      pend <= '0;
    end else begin
      pend <= (pend & ~pend_clr) | pend_set;
    end
  end

  assign irf_hit = pend[irf_idx];

  ////////////////////
  // Acknowledge state

  // MK bits 0..3 mask the sources in index order
  assign enabled = {periph_pkg::num_int{ie}} & ~mk[periph_pkg::num_int-1:0];

  always_ff @(posedge CLK) begin
    if (rst) begin
      taken <= '0;
      ie    <= 1'b0;
    end else begin
      if (fetch) begin
        taken <= pend & ~ack_clr & enabled;
      end
      if (fetch && int_req) begin
        ie <= 1'b0;
      end else if (ie_wr) begin
        ie <= ie_val;
      end
    end
  end

  // Priority encoder
  always_comb begin
    ack = '0;
    for (int i = periph_pkg::num_int - 1; i >= 0; i--) begin
      if (taken[i]) begin
        ack    = '0;
        ack[i] = 1'b1;
      end
    end
  end

  assign int_req = |taken;

  always_comb begin
    case (1'b1)
      ack[periph_pkg::ii_int0]: int_vector = periph_pkg::vec_int0;
      ack[periph_pkg::ii_intt]: int_vector = periph_pkg::vec_intt;
      ack[periph_pkg::ii_int1]: int_vector = periph_pkg::vec_int1;
      ack[periph_pkg::ii_int2]: int_vector = periph_pkg::vec_int2;
      default:                  int_vector = '0;
    endcase
  end

endmodule

// File: design/periph_top.sv
// Peripheral block top; CPU side is plain one-cycle strobes with no handshake
`timescale 1ns/1ns

module periph_top (
  input  logic                          CLK,
  input  logic                          rst,
  input  logic                          spr_wr,
  input  periph_pkg::spr_sel_t          spr_sel,
  input  logic [periph_pkg::data_w-1:0] spr_wdata,
  output logic [periph_pkg::data_w-1:0] spr_rdata,
  input  logic                          stm,
  input  logic                          fetch,
  input  logic                          ie_wr,
  input  logic                          ie_val,
  input  logic                          irf_clr,
  input  periph_pkg::int_idx_t          irf_idx,
  input  logic                          int0,
  input  logic                          int1,
  input  logic                          int2,
  input  logic [periph_pkg::data_w-1:0] pb_in,
  input  logic [periph_pkg::data_w-1:0] pc_in,
  output logic [periph_pkg::data_w-1:0] pa_out,
  output logic [periph_pkg::data_w-1:0] pb_out,
  output logic [periph_pkg::data_w-1:0] pb_oe,
  output logic [periph_pkg::data_w-1:0] pc_out,
  output logic [periph_pkg::data_w-1:0] pc_oe,
  output logic                          int_req,
  output periph_pkg::int_vec_t          int_vector,
  output logic                          ie,
  output logic                          irf_hit
);

  logic [periph_pkg::data_w-1:0] mk;
  logic [periph_pkg::tm_w-1:0]   tm_reload;
  logic                          timer_uf;

  ////////////////////
  // Register file and ports

  spr_file u_spr_file (
    .CLK       (CLK),
    .rst       (rst),
    .spr_wr    (spr_wr),
    .spr_sel   (spr_sel),
    .spr_wdata (spr_wdata),
    .pb_in     (pb_in),
    .pc_in     (pc_in),
    .spr_rdata (spr_rdata),
    .pa_out    (pa_out),
    .pb_out    (pb_out),
    .pb_oe     (pb_oe),
    .pc_out    (pc_out),
    .pc_oe     (pc_oe),
    .mk        (mk),
    .tm_reload (tm_reload)
  );

  timer u_timer (
    .CLK       (CLK),
    .rst       (rst),
    .stm       (stm),
    .tm_reload (tm_reload),
    .timer_uf  (timer_uf)
  );

  ////////////////////
  // Interrupts

  int_ctrl u_int_ctrl (
    .CLK        (CLK),
    .rst        (rst),
    .int0       (int0),
    .int1       (int1),
    .int2       (int2),
    .timer_uf   (timer_uf),
    .mk         (mk),
    .fetch      (fetch),
    .ie_wr      (ie_wr),
    .ie_val     (ie_val),
    .irf_clr    (irf_clr),
    .irf_idx    (irf_idx),
    .int_req    (int_req),
    .int_vector (int_vector),
    .ie         (ie),
    .irf_hit    (irf_hit)
  );

endmodule

// File: tb/tb_periph.sv
// Directed testbench for periph_top; timer test keeps the reload below 7 so the watchdog budget holds
`timescale 1ns/1ns

module tb_periph;

  typedef logic [periph_pkg::data_w-1:0] word_t;

  localparam int clk_half   = 2;
  localparam int drive_skew = 1;
  localparam int rst_cycles = 8;
  localparam int port_loops = 4;
  localparam int max_n      = 6;

  // Worst-case cycles per test
  localparam int budget_reset    = 16;
  localparam int budget_ports    = port_loops * 10;
  localparam int budget_timer    = (max_n + 1) * 8 + 4 + 12;
  localparam int budget_edge     = 24;
  localparam int budget_prio     = 16;
  localparam int budget_int2     = 24;
  localparam int watchdog_cycles = rst_cycles + budget_reset + budget_ports + budget_timer
                                   + budget_edge + budget_prio + budget_int2 + 50;

  logic                 CLK;
  logic                 rst;
  logic                 spr_wr;
  periph_pkg::spr_sel_t spr_sel;
  word_t                spr_wdata;
  word_t                spr_rdata;
  logic                 stm;
  logic                 fetch;
  logic                 ie_wr;
  logic                 ie_val;
  logic                 irf_clr;
  periph_pkg::int_idx_t irf_idx;
  logic                 int0;
  logic                 int1;
  logic                 int2;
  word_t                pb_in;
  word_t                pc_in;
  word_t                pa_out;
  word_t                pb_out;
  word_t                pb_oe;
  word_t                pc_out;
  word_t                pc_oe;
  logic                 int_req;
  periph_pkg::int_vec_t int_vector;
  logic                 ie;
  logic                 irf_hit;

  periph_top uut (
    .CLK        (CLK),
    .rst        (rst),
    .spr_wr     (spr_wr),
    .spr_sel    (spr_sel),
    .spr_wdata  (spr_wdata),
    .spr_rdata  (spr_rdata),
    .stm        (stm),
    .fetch      (fetch),
    .ie_wr      (ie_wr),
    .ie_val     (ie_val),
    .irf_clr    (irf_clr),
    .irf_idx    (irf_idx),
    .int0       (int0),
    .int1       (int1),
    .int2       (int2),
    .pb_in      (pb_in),
    .pc_in      (pc_in),
    .pa_out     (pa_out),
    .pb_out     (pb_out),
    .pb_oe      (pb_oe),
    .pc_out     (pc_out),
    .pc_oe      (pc_oe),
    .int_req    (int_req),
    .int_vector (int_vector),
    .ie         (ie),
    .irf_hit    (irf_hit)
  );

  initial begin
    CLK = 1'b0;
    forever #clk_half CLK = ~CLK;
  end

  ////////////////////
  // Error handling and compares

  task automatic stop_on_error(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_data(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_vec(input string name, input periph_pkg::int_vec_t got,
                           input periph_pkg::int_vec_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge CLK);
    stop_on_error("watchdog expired before all tests completed");
  end

  ////////////////////
  // Bus helpers

  // Inputs change just after the rising edge
  task automatic step();
    @(posedge CLK);
    #drive_skew;
  endtask

  task automatic write_spr(input periph_pkg::spr_sel_t sel, input word_t data);
    spr_sel   = sel;
    spr_wdata = data;
    spr_wr    = 1'b1;
    step();
    spr_wr = 1'b0;
  endtask

  task automatic check_read(input periph_pkg::spr_sel_t sel, input word_t exp, input string name);
    spr_sel = sel;
    step();
    check_data(name, spr_rdata, exp);
  endtask

  task automatic set_ie(input logic val);
    ie_val = val;
    ie_wr  = 1'b1;
    step();
    ie_wr = 1'b0;
  endtask

  // PC7 and PC1..PC0 outputs when MC bit clear, PC6..PC3 always out, PC2 always in
  function automatic word_t expected_pc_oe(input word_t mc);
    word_t oe;
    oe[7]   = ~mc[7];
    oe[6:2] = 5'b11110;
    oe[1:0] = ~mc[1:0];
    return oe;
  endfunction

  // PC7..PC2 pass the latch where MC is set, PC1..PC0 where MC is clear
  function automatic word_t expected_pc_out(input word_t pc, input word_t mc);
    word_t r;
    for (int b = 0; b < periph_pkg::data_w; b++) begin
      if (b >= 2) begin
        r[b] = mc[b] ? pc[b] : 1'b0;
      end else begin
        r[b] = mc[b] ? 1'b0 : pc[b];
      end
    end
    return r;
  endfunction

  // Output pins read the latch, input pins read the pin
  function automatic word_t pin_readback(input word_t latch, input word_t pins, input word_t oe);
    word_t r;
    for (int b = 0; b < periph_pkg::data_w; b++) begin
      r[b] = oe[b] ? latch[b] : pins[b];
    end
    return r;
  endfunction

  ////////////////////
  // Tests

  task automatic test_reset();
    check_read(periph_pkg::spr_mk, 8'hff, "MK");
    check_read(periph_pkg::spr_mb, 8'hff, "MB");
    check_read(periph_pkg::spr_mc, 8'hff, "MC");
    check_read(periph_pkg::spr_pa, 8'h00, "PA");
    check_read(periph_pkg::spr_pb, 8'h00, "PB");
    check_read(periph_pkg::spr_pc, 8'h00, "PC");
    check_read(periph_pkg::spr_tm0, 8'hff, "TM0");
    check_read(periph_pkg::spr_tm1, 8'h0f, "TM1");
    check_data("pa_out", pa_out, 8'h00);
    check_data("pb_out", pb_out, 8'h00);
    check_data("pc_out", pc_out, 8'h00);
    check_data("pb_oe", pb_oe, 8'h00);
    check_data("pc_oe", pc_oe, expected_pc_oe(8'hff));
    check_bit("int_req", int_req, 1'b0);
    check_bit("ie", ie, 1'b0);
  endtask

  task automatic test_ports();
    word_t pa;
    word_t pb;
    word_t pc;
    word_t mb;
    word_t mc;
    for (int i = 0; i < port_loops; i++) begin
      pa    = word_t'($urandom);
      pb    = word_t'($urandom);
      pc    = word_t'($urandom);
      mb    = word_t'($urandom);
      mc    = word_t'($urandom);
      pb_in = word_t'($urandom);
      pc_in = word_t'($urandom);
      write_spr(periph_pkg::spr_pa, pa);
      write_spr(periph_pkg::spr_pb, pb);
      write_spr(periph_pkg::spr_pc, pc);
      write_spr(periph_pkg::spr_mb, mb);
      write_spr(periph_pkg::spr_mc, mc);
      check_data("pa_out", pa_out, pa);
      check_data("pb_out", pb_out, pb);
      check_data("pb_oe", pb_oe, ~mb);
      check_data("pc_oe", pc_oe, expected_pc_oe(mc));
      check_data("pc_out", pc_out, expected_pc_out(pc, mc));
      check_read(periph_pkg::spr_pb, pin_readback(pb, pb_in, ~mb), "PB");
      check_read(periph_pkg::spr_pc, pin_readback(pc, pc_in, expected_pc_oe(mc)), "PC");
    end
  endtask

  task automatic test_timer_irq();
    word_t n;
    int    limit;
    int    cycles;
    logic  seen;
    n     = word_t'(2 + $urandom % (max_n - 1));
    limit = (int'(n) + 1) * 8 + 4;
    // Only INTT unmasked, INT2 rising edge
    write_spr(periph_pkg::spr_mk, 8'hfd);
    set_ie(1'b1);
    write_spr(periph_pkg::spr_tm0, n);
    write_spr(periph_pkg::spr_tm1, 8'h00);
    stm = 1'b1;
    step();
    stm    = 1'b0;
    fetch  = 1'b1;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < limit) begin
      step();
      cycles++;
      seen = int_req;
    end
    if (!seen) begin
      stop_on_error($sformatf("timer interrupt not requested within %0d cycles", limit));
    end
    check_vec("int_vector", int_vector, periph_pkg::vec_intt);
    // One more fetch takes the request and drops ie
    step();
    fetch = 1'b0;
    check_bit("ie", ie, 1'b0);
    check_bit("int_req", int_req, 1'b0);
  endtask

  task automatic test_edge_filter();
    int hit_at;
    irf_idx = periph_pkg::ii_int1;
    int1    = 1'b0;
    step();
    int1 = 1'b1;
    step();
    step();
    int1 = 1'b0;
    for (int k = 0; k < 8; k++) begin
      step();
      check_bit("irf_hit", irf_hit, 1'b0);
    end
    hit_at = 0;
    int1   = 1'b1;
    for (int k = 1; k <= 6; k++) begin
      step();
      if (k == 5) begin
        int1 = 1'b0;
      end
      if (irf_hit && hit_at == 0) begin
        hit_at = k;
      end
    end
    if (hit_at == 0) begin
      stop_on_error("INT1 flag not set within 6 cycles of a 5-cycle pulse");
    end
    irf_clr = 1'b1;
    step();
    irf_clr = 1'b0;
    check_bit("irf_hit", irf_hit, 1'b0);
  endtask

  task automatic test_priority();
    // INT0 and INT1 unmasked, INTT and INT2 masked
    write_spr(periph_pkg::spr_mk, 8'hfa);
    irf_idx = periph_pkg::ii_int1;
    int0    = 1'b1;
    int1    = 1'b1;
    repeat (5) step();
    check_bit("irf_hit", irf_hit, 1'b1);
    set_ie(1'b1);
    fetch = 1'b1;
    step();
    fetch = 1'b0;
    check_bit("int_req", int_req, 1'b1);
    check_vec("int_vector", int_vector, periph_pkg::vec_int0);
    int0 = 1'b0;
    int1 = 1'b0;
    step();
    set_ie(1'b1);
    fetch = 1'b1;
    step();
    fetch = 1'b0;
    check_bit("int_req", int_req, 1'b1);
    check_vec("int_vector", int_vector, periph_pkg::vec_int1);
    check_bit("ie", ie, 1'b0);
    // With ie low the last fetch retires INT1 and takes nothing
    fetch = 1'b1;
    step();
    fetch = 1'b0;
    check_bit("int_req", int_req, 1'b0);
    check_bit("irf_hit", irf_hit, 1'b0);
  endtask

  task automatic test_int2_polarity();
    int hit_at;
    irf_idx = periph_pkg::ii_int2;
    int2    = 1'b1;
    repeat (6) step();
    // MK5 clear, falling edge now counts
    write_spr(periph_pkg::spr_mk, 8'hdf);
    repeat (4) step();
    irf_clr = 1'b1;
    step();
    irf_clr = 1'b0;
    check_bit("irf_hit", irf_hit, 1'b0);
    hit_at = 0;
    int2   = 1'b0;
    for (int k = 1; k <= 5; k++) begin
      step();
      if (k == 4) begin
        int2 = 1'b1;
      end
      if (irf_hit && hit_at == 0) begin
        hit_at = k;
      end
    end
    if (hit_at == 0) begin
      stop_on_error("INT2 flag not set by a falling edge with MK bit 5 clear");
    end
  endtask

  ////////////////////
  // Main sequence

  initial begin
    void'($urandom(32'h33f3bf9c));
    rst       = 1'b1;
    spr_wr    = 1'b0;
    spr_sel   = periph_pkg::spr_pa;
    spr_wdata = 8'h00;
    stm       = 1'b0;
    fetch     = 1'b0;
    ie_wr     = 1'b0;
    ie_val    = 1'b0;
    irf_clr   = 1'b0;
    irf_idx   = periph_pkg::ii_int0;
    int0      = 1'b0;
    int1      = 1'b0;
    int2      = 1'b0;
    pb_in     = 8'h00;
    pc_in     = 8'h00;
    repeat (rst_cycles) @(posedge CLK);
    #drive_skew;
    rst = 1'b0;
    test_reset();
    test_ports();
    test_timer_irq();
    test_edge_filter();
    test_priority();
    test_int2_polarity();
    $display("test passed");
    $finish;
  end

endmodule

// File: upd7800_periph.f
design/periph_pkg.sv
design/spr_file.sv
design/timer.sv
design/int_ctrl.sv
design/periph_top.sv
tb/tb_periph.sv

// File: Makefile
# Verilator build and run of the peripheral block testbench
VERILATOR ?= verilator
TOP       ?= tb_periph
FILELIST  ?= upd7800_periph.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing

SOURCES := $(shell cat $(FILELIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status is nonzero when the testbench stops on $fatal
run: compile
	./$(BINARY)

clean:
	rm -rf $(BUILD_DIR)
